//--- hdl/PixelFifo.sv
// Pixel FIFO, first-word-fall-through, returning one credit per popped pixel
`timescale 1ns/1ps

module PixelFifo (
	input  logic               sysClk,
	input  logic               rstN,
	input  VideoTxPkg::pixelT  memRd,
	input  logic               memRVd,
	input  logic               pixelPop,
	output VideoTxPkg::pixelT  pixelData,
	output logic               pixelValid,
	output logic               creditReturn
);

	VideoTxPkg::pixelT                        mem [VideoTxPkg::PixelFifoDepth];
	logic [VideoTxPkg::PixelFifoAdrsBits-1:0] wrPtr;
	logic [VideoTxPkg::PixelFifoAdrsBits-1:0] rdPtr;
	// Occupancy shares the credit width, 0 to depth
	VideoTxPkg::creditT                       count;

	// Head entry shown with no delay
	assign pixelValid = count != '0;
	assign pixelData  = mem[rdPtr];

	// Credits keep the push side from overrunning the array
	always_ff @(posedge sysClk)
	begin
		if (memRVd)
			mem[wrPtr] <= memRd;
	end

	// ----------------------------------------------------------
	// Pointers and occupancy
	// ----------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr        <= '0;
			rdPtr        <= '0;
			count        <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (memRVd)
				wrPtr <= wrPtr + 1'b1;
			if (pixelPop)
				rdPtr <= rdPtr + 1'b1;
			case ({memRVd, pixelPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			creditReturn <= pixelPop;
		end
	end

endmodule

//--- hdl/TftDriver.sv
// TFT output driver with timing counters, syncs, data enable, colour, underrun and backlight
`timescale 1ns/1ps

module TftDriver (
	input  logic               sysClk,
	input  logic               rstN,
	input  VideoTxPkg::countT  hdisplay,
	input  VideoTxPkg::countT  vdisplay,
	input  VideoTxPkg::countT  hSyncStart,
	input  VideoTxPkg::countT  hSyncEnd,
	input  VideoTxPkg::countT  hSyncMax,
	input  VideoTxPkg::countT  vSyncStart,
	input  VideoTxPkg::countT  vSyncEnd,
	input  VideoTxPkg::countT  vSyncMax,
	input  logic               displayRst,
	input  logic [7:0]         blDuty,
	input  VideoTxPkg::pixelT  pixelData,
	input  logic               pixelValid,
	output logic               pixelPop,
	output logic               underrun,
	output logic [3:0]         tftColorR,
	output logic [3:0]         tftColorG,
	output logic [3:0]         tftColorB,
	output logic               tftHSync,
	output logic               tftVSync,
	output logic               tftDe,
	output logic               tftRst,
	output logic               tftBackLight
);

	VideoTxPkg::countT hCount;
	VideoTxPkg::countT vCount;
	logic              active;
	logic              hSyncZone;
	logic              vSyncZone;
	logic [7:0]        blCount;

	assign active    = !displayRst && (hCount < hdisplay) && (vCount < vdisplay);
	assign hSyncZone = (hCount >= hSyncStart) && (hCount < hSyncEnd);
	assign vSyncZone = (vCount >= vSyncStart) && (vCount < vSyncEnd);
	assign pixelPop  = active && pixelValid;
	assign tftRst    = !displayRst;

	// ----------------------------------------------------------
	// Horizontal and vertical counters
	// ----------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (displayRst)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (hCount == hSyncMax)
		begin
			hCount <= '0;
			if (vCount == vSyncMax)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end
		else
			hCount <= hCount + 1'b1;
	end

	// ----------------------------------------------------------
	// Registered panel outputs, one cycle behind the counters
	// ----------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			tftDe     <= 1'b0;
			tftHSync  <= 1'b1;
			tftVSync  <= 1'b1;
			tftColorR <= '0;
			tftColorG <= '0;
			tftColorB <= '0;
		end
		else
		begin
			tftDe    <= active;
			// Syncs stay inactive while the display is held in reset
			tftHSync <= displayRst || !hSyncZone;
			tftVSync <= displayRst || !vSyncZone;
			if (pixelPop)
			begin
				// RGB565 reduced to 4 bits per channel
				tftColorR <= pixelData[15:12];
				tftColorG <= pixelData[10:7];
				tftColorB <= pixelData[4:1];
			end
			else
			begin
				tftColorR <= '0;
				tftColorG <= '0;
				tftColorB <= '0;
			end
		end
	end

	// Sticky until the display goes back into reset
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
			underrun <= 1'b0;
		else if (displayRst)
			underrun <= 1'b0;
		else if (active && !pixelValid)
			underrun <= 1'b1;
	end

	// Backlight PWM, 256-cycle period
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			blCount      <= '0;
			tftBackLight <= 1'b0;
		end
		else
		begin
			blCount      <= blCount + 1'b1;
			tftBackLight <= blCount < blDuty;
		end
	end

endmodule

//--- hdl/VideoDmaReader.sv
// Video DMA reader looping over the frame buffer, paced by pixel FIFO credits
`timescale 1ns/1ps

module VideoDmaReader (
	input  logic                 sysClk,
	input  logic                 rstN,
	input  logic                 dmaEn,
	input  VideoTxPkg::memAdrsT  dmaAdrs,
	input  VideoTxPkg::memAdrsT  dmaLen,
	input  logic                 creditReturn,
	input  logic                 memRdy,
	output VideoTxPkg::memAdrsT  memAdrs,
	output logic                 memREd
);

	VideoTxPkg::dmaStateT state;
	VideoTxPkg::creditT   credits;
	VideoTxPkg::memAdrsT  wordCnt;
	logic                 accept;
	logic                 lastWord;

	// Request only while a FIFO slot is guaranteed
	assign memREd   = (state == VideoTxPkg::DmaRun) && (credits != '0);
	assign accept   = memREd && memRdy;
	assign lastWord = (wordCnt + 1'b1) >= dmaLen;

	// ----------------------------------------------------------
	// Address FSM
	// ----------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state   <= VideoTxPkg::DmaIdle;
			memAdrs <= '0;
			wordCnt <= '0;
		end
		else
		begin
			case (state)
				VideoTxPkg::DmaIdle:
				begin
					if (dmaEn)
					begin
						state   <= VideoTxPkg::DmaRun;
						memAdrs <= dmaAdrs;
						wordCnt <= '0;
					end
				end
				VideoTxPkg::DmaRun:
				begin
					if (!dmaEn)
						state <= VideoTxPkg::DmaIdle;
					else if (accept)
					begin
						// Wrap to the start of the window after dmaLen words
						if (lastWord)
						begin
							memAdrs <= dmaAdrs;
							wordCnt <= '0;
						end
						else
						begin
							memAdrs <= memAdrs + 1'b1;
							wordCnt <= wordCnt + 1'b1;
						end
					end
				end
				default: state <= VideoTxPkg::DmaIdle;
			endcase
		end
	end

	// Credits survive DMA stop, data in flight still lands in the FIFO
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
			credits <= VideoTxPkg::creditT'(VideoTxPkg::PixelFifoDepth);
		else
		begin
			case ({accept, creditReturn})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

//--- hdl/VideoTxBlock.sv
// Video Tx top level joining registers, DMA reader, pixel FIFO and TFT driver
`timescale 1ns/1ps

module VideoTxBlock (
	input  logic                 sysClk,
	input  logic                 rstN,
	// Register bus
	input  VideoTxPkg::busAdrsT  csrAdrs,
	input  VideoTxPkg::csrDataT  csrWd,
	input  logic                 csrWCke,
	output VideoTxPkg::csrDataT  csrRd,
	output logic                 csrREd,
	// Memory read bus
	input  logic                 memRdy,
	input  VideoTxPkg::pixelT    memRd,
	input  logic                 memRVd,
	output VideoTxPkg::memAdrsT  memAdrs,
	output logic                 memREd,
	// Panel
	output logic [3:0]           tftColorR,
	output logic [3:0]           tftColorG,
	output logic [3:0]           tftColorB,
	output logic                 tftHSync,
	output logic                 tftVSync,
	output logic                 tftDe,
	output logic                 tftRst,
	output logic                 tftBackLight
);

	VideoTxPkg::countT   hdisplay;
	VideoTxPkg::countT   vdisplay;
	VideoTxPkg::countT   hSyncStart;
	VideoTxPkg::countT   hSyncEnd;
	VideoTxPkg::countT   hSyncMax;
	VideoTxPkg::countT   vSyncStart;
	VideoTxPkg::countT   vSyncEnd;
	VideoTxPkg::countT   vSyncMax;
	logic                displayRst;
	logic                dmaEn;
	logic [7:0]          blDuty;
	VideoTxPkg::memAdrsT dmaAdrs;
	VideoTxPkg::memAdrsT dmaLen;
	logic                underrun;
	logic                creditReturn;
	VideoTxPkg::pixelT   pixelData;
	logic                pixelValid;
	logic                pixelPop;

	// ----------------------------------------------------------
	// Input side
	// ----------------------------------------------------------
	VideoTxCsr csr (
		.sysClk(sysClk), .rstN(rstN),
		.csrAdrs(csrAdrs), .csrWd(csrWd), .csrWCke(csrWCke), .underrun(underrun),
		.csrRd(csrRd), .csrREd(csrREd),
		.hdisplay(hdisplay), .vdisplay(vdisplay),
		.hSyncStart(hSyncStart), .hSyncEnd(hSyncEnd), .hSyncMax(hSyncMax),
		.vSyncStart(vSyncStart), .vSyncEnd(vSyncEnd), .vSyncMax(vSyncMax),
		.displayRst(displayRst), .dmaEn(dmaEn), .blDuty(blDuty),
		.dmaAdrs(dmaAdrs), .dmaLen(dmaLen)
	);

	VideoDmaReader dmaReader (
		.sysClk(sysClk), .rstN(rstN),
		.dmaEn(dmaEn), .dmaAdrs(dmaAdrs), .dmaLen(dmaLen),
		.creditReturn(creditReturn), .memRdy(memRdy),
		.memAdrs(memAdrs), .memREd(memREd)
	);

	// Read data goes straight into the FIFO
	PixelFifo pixelFifo (
		.sysClk(sysClk), .rstN(rstN),
		.memRd(memRd), .memRVd(memRVd), .pixelPop(pixelPop),
		.pixelData(pixelData), .pixelValid(pixelValid), .creditReturn(creditReturn)
	);

	// ----------------------------------------------------------
	// Output side
	// ----------------------------------------------------------
	TftDriver tftDriver (
		.sysClk(sysClk), .rstN(rstN),
		.hdisplay(hdisplay), .vdisplay(vdisplay),
		.hSyncStart(hSyncStart), .hSyncEnd(hSyncEnd), .hSyncMax(hSyncMax),
		.vSyncStart(vSyncStart), .vSyncEnd(vSyncEnd), .vSyncMax(vSyncMax),
		.displayRst(displayRst), .blDuty(blDuty),
		.pixelData(pixelData), .pixelValid(pixelValid),
		.pixelPop(pixelPop), .underrun(underrun),
		.tftColorR(tftColorR), .tftColorG(tftColorG), .tftColorB(tftColorB),
		.tftHSync(tftHSync), .tftVSync(tftVSync), .tftDe(tftDe),
		.tftRst(tftRst), .tftBackLight(tftBackLight)
	);

endmodule

//--- hdl/VideoTxCsr.sv
// Video Tx register block holding display timing, control, backlight and DMA window
`timescale 1ns/1ps

module VideoTxCsr (
	input  logic                 sysClk,
	input  logic                 rstN,
	input  VideoTxPkg::busAdrsT  csrAdrs,
	input  VideoTxPkg::csrDataT  csrWd,
	input  logic                 csrWCke,
	input  logic                 underrun,
	output VideoTxPkg::csrDataT  csrRd,
	output logic                 csrREd,
	output VideoTxPkg::countT    hdisplay,
	output VideoTxPkg::countT    vdisplay,
	output VideoTxPkg::countT    hSyncStart,
	output VideoTxPkg::countT    hSyncEnd,
	output VideoTxPkg::countT    hSyncMax,
	output VideoTxPkg::countT    vSyncStart,
	output VideoTxPkg::countT    vSyncEnd,
	output VideoTxPkg::countT    vSyncMax,
	output logic                 displayRst,
	output logic                 dmaEn,
	output logic [7:0]           blDuty,
	output VideoTxPkg::memAdrsT  dmaAdrs,
	output VideoTxPkg::memAdrsT  dmaLen
);

	logic                hit;
	logic [7:0]          offset;
	VideoTxPkg::csrDataT readValue;

	// Upper byte selects the block, lower byte the register
	assign hit    = csrAdrs[VideoTxPkg::BusAdrsBits-1 -: 8] == VideoTxPkg::BlockAdrsMap;
	assign offset = csrAdrs[7:0];

	// ----------------------------------------------------------
	// Register write
	// ----------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hdisplay   <= VideoTxPkg::DefHdisplay;
			vdisplay   <= VideoTxPkg::DefVdisplay;
			hSyncStart <= VideoTxPkg::DefHSyncStart;
			hSyncEnd   <= VideoTxPkg::DefHSyncEnd;
			hSyncMax   <= VideoTxPkg::DefHSyncMax;
			vSyncStart <= VideoTxPkg::DefVSyncStart;
			vSyncEnd   <= VideoTxPkg::DefVSyncEnd;
			vSyncMax   <= VideoTxPkg::DefVSyncMax;
			displayRst <= VideoTxPkg::DefControl[0];
			dmaEn      <= VideoTxPkg::DefControl[1];
			blDuty     <= VideoTxPkg::DefBlDuty;
			dmaAdrs    <= VideoTxPkg::DefDmaAdrs;
			dmaLen     <= VideoTxPkg::DefDmaLen;
		end
		else if (hit && csrWCke)
		begin
			case (offset)
				VideoTxPkg::RegHdisplay:   hdisplay   <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegVdisplay:   vdisplay   <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegHSyncStart: hSyncStart <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegHSyncEnd:   hSyncEnd   <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegHSyncMax:   hSyncMax   <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegVSyncStart: vSyncStart <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegVSyncEnd:   vSyncEnd   <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegVSyncMax:   vSyncMax   <= csrWd[VideoTxPkg::CountBits-1:0];
				VideoTxPkg::RegControl:
				begin
					displayRst <= csrWd[0];
					dmaEn      <= csrWd[1];
				end
				VideoTxPkg::RegBlDuty:     blDuty     <= csrWd[7:0];
				VideoTxPkg::RegDmaAdrs:    dmaAdrs    <= csrWd[VideoTxPkg::MemAdrsBits-1:0];
				VideoTxPkg::RegDmaLen:     dmaLen     <= csrWd[VideoTxPkg::MemAdrsBits-1:0];
				default:;
			endcase
		end
	end

	// ----------------------------------------------------------
	// Read-back
	// ----------------------------------------------------------
	always_comb
	begin
		case (offset)
			VideoTxPkg::RegHdisplay:   readValue = VideoTxPkg::csrDataT'(hdisplay);
			VideoTxPkg::RegVdisplay:   readValue = VideoTxPkg::csrDataT'(vdisplay);
			VideoTxPkg::RegHSyncStart: readValue = VideoTxPkg::csrDataT'(hSyncStart);
			VideoTxPkg::RegHSyncEnd:   readValue = VideoTxPkg::csrDataT'(hSyncEnd);
			VideoTxPkg::RegHSyncMax:   readValue = VideoTxPkg::csrDataT'(hSyncMax);
			VideoTxPkg::RegVSyncStart: readValue = VideoTxPkg::csrDataT'(vSyncStart);
			VideoTxPkg::RegVSyncEnd:   readValue = VideoTxPkg::csrDataT'(vSyncEnd);
			VideoTxPkg::RegVSyncMax:   readValue = VideoTxPkg::csrDataT'(vSyncMax);
			VideoTxPkg::RegControl:    readValue = VideoTxPkg::csrDataT'({dmaEn, displayRst});
			VideoTxPkg::RegBlDuty:     readValue = VideoTxPkg::csrDataT'(blDuty);
			VideoTxPkg::RegDmaAdrs:    readValue = VideoTxPkg::csrDataT'(dmaAdrs);
			VideoTxPkg::RegDmaLen:     readValue = VideoTxPkg::csrDataT'(dmaLen);
			// Live status, not latched here
			VideoTxPkg::RegStatus:     readValue = VideoTxPkg::csrDataT'(underrun);
			default:                   readValue = '0;
		endcase
	end

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
			csrREd <= 1'b0;
		else
			csrREd <= hit && !csrWCke;
	end

	always_ff @(posedge sysClk)
	begin
		csrRd <= readValue;
	end

endmodule

//--- hdl/VideoTxPkg.sv
// Video Tx package with bus widths, register map, reset defaults and shared types
package VideoTxPkg;

	// ----------------------------------------------------------
	// Widths
	// ----------------------------------------------------------
	localparam int BusAdrsBits = 16;
	localparam int CsrDataBits = 32;
	localparam int PixelBits   = 16;
	localparam int MemAdrsBits = 19;
	localparam int CountBits   = 12;

	typedef logic [BusAdrsBits-1:0] busAdrsT;
	typedef logic [CsrDataBits-1:0] csrDataT;
	typedef logic [PixelBits-1:0]   pixelT;
	typedef logic [MemAdrsBits-1:0] memAdrsT;
	typedef logic [CountBits-1:0]   countT;

	// Pixel FIFO size doubles as the starting credit count
	localparam int PixelFifoDepth    = 16;
	localparam int PixelFifoAdrsBits = $clog2(PixelFifoDepth);
	localparam int CreditBits        = 5;

	typedef logic [CreditBits-1:0] creditT;

	// Upper address byte of this block
	localparam logic [7:0] BlockAdrsMap = 8'h04;

	// ----------------------------------------------------------
	// Register offsets
	// ----------------------------------------------------------
	localparam logic [7:0] RegHdisplay   = 8'h00;
	localparam logic [7:0] RegVdisplay   = 8'h04;
	localparam logic [7:0] RegHSyncStart = 8'h08;
	localparam logic [7:0] RegHSyncEnd   = 8'h0C;
	localparam logic [7:0] RegHSyncMax   = 8'h10;
	localparam logic [7:0] RegVSyncStart = 8'h14;
	localparam logic [7:0] RegVSyncEnd   = 8'h18;
	localparam logic [7:0] RegVSyncMax   = 8'h1C;
	localparam logic [7:0] RegControl    = 8'h20;
	localparam logic [7:0] RegBlDuty     = 8'h24;
	localparam logic [7:0] RegDmaAdrs    = 8'h28;
	localparam logic [7:0] RegDmaLen     = 8'h2C;
	localparam logic [7:0] RegStatus     = 8'h30;

	// 480x272 panel timing
	localparam countT DefHdisplay   = 12'd480;
	localparam countT DefHSyncStart = 12'd488;
	localparam countT DefHSyncEnd   = 12'd498;
	localparam countT DefHSyncMax   = 12'd540;
	localparam countT DefVdisplay   = 12'd272;
	localparam countT DefVSyncStart = 12'd284;
	localparam countT DefVSyncEnd   = 12'd294;
	localparam countT DefVSyncMax   = 12'd297;

	// Display held in reset, DMA off
	localparam logic [1:0] DefControl = 2'b01;
	localparam logic [7:0] DefBlDuty  = 8'd0;
	localparam memAdrsT    DefDmaAdrs = '0;
	localparam memAdrsT    DefDmaLen  = '0;

	typedef enum logic
	{
		DmaIdle,
		DmaRun
	} dmaStateT;

endpackage

//--- run.sh
#!/bin/sh
# Build the Video Tx testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module VideoTxBlockTb -f src.f -o VideoTxBlockTb

output=$(./obj_dir/VideoTxBlockTb)
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	exit 1
fi

//--- src.f
hdl/VideoTxPkg.sv
hdl/VideoTxCsr.sv
hdl/VideoDmaReader.sv
hdl/PixelFifo.sv
hdl/TftDriver.sv
hdl/VideoTxBlock.sv
testbench/UfiMemModel.sv
testbench/VideoTxBlockTb.sv

//--- testbench/UfiMemModel.sv
// Frame-buffer memory model with random ready, in-order random latency and a read limit check
`timescale 1ns/1ps

module UfiMemModel (
	input  logic                 sysClk,
	input  VideoTxPkg::memAdrsT  memAdrs,
	input  logic                 memREd,
	input  logic                 stall,
	output logic                 memRdy,
	output VideoTxPkg::pixelT    memRd,
	output logic                 memRVd,
	output int                   limitErrors
);

	VideoTxPkg::pixelT   dataQ [$];
	int                  dueQ [$];
	int                  cycle;
	int                  lastDue;
	int                  due;
	int                  latency;
	logic                take;
	logic                stallNow;
	VideoTxPkg::memAdrsT takeAdrs;

	initial
	begin
		memRdy      = 1'b0;
		memRd       = '0;
		memRVd      = 1'b0;
		limitErrors = 0;
		cycle       = 0;
		lastDue     = 0;
		forever
		begin
			// Values at the falling edge are the ones the next rising edge sees
			@(negedge sysClk);
			take     = memREd && memRdy;
			takeAdrs = memAdrs;
			stallNow = stall;
			@(posedge sysClk);
			#1;
			cycle++;
			if (take)
			begin
				// Latency 1 puts the data in the cycle right after the accepting edge
				latency = $urandom_range(1, 4);
				due     = cycle + latency - 1;
				if (due <= lastDue)
					due = lastDue + 1;
				lastDue = due;
				dataQ.push_back(VideoTxPkg::pixelT'(32'(takeAdrs) * 32'h9E37 + 32'h1234));
				dueQ.push_back(due);
				assert (dataQ.size() <= VideoTxPkg::PixelFifoDepth)
				else
				begin
					limitErrors++;
					$display("Memory model: %0d reads outstanding, more than the FIFO depth of %0d",
						dataQ.size(), VideoTxPkg::PixelFifoDepth);
				end
			end
			// Return path, oldest request first
			if (dueQ.size() > 0 && dueQ[0] <= cycle)
			begin
				memRVd = 1'b1;
				memRd  = dataQ.pop_front();
				void'(dueQ.pop_front());
			end
			else
			begin
				memRVd = 1'b0;
				memRd  = '0;
			end
			memRdy = !stallNow && ($urandom_range(0, 3) != 0);
		end
	end

endmodule

//--- testbench/VideoTxBlockTb.sv
// Video Tx testbench with register, sync, pixel, backlight and underrun checks
`timescale 1ns/1ps

module VideoTxBlockTb;

	localparam int ClkPeriod       = 100;
	localparam int PanelHdisplay   = 8;
	localparam int PanelVdisplay   = 4;
	localparam int PanelHSyncStart = 10;
	localparam int PanelHSyncEnd   = 12;
	localparam int PanelHSyncMax   = 15;
	localparam int PanelVSyncStart = 5;
	localparam int PanelVSyncEnd   = 6;
	localparam int PanelVSyncMax   = 7;
	localparam int DmaBase         = 'h1A0;
	localparam int DmaWords        = 32;
	localparam int LineCycles      = PanelHSyncMax + 1;
	localparam int FrameCycles     = LineCycles * (PanelVSyncMax + 1);
	localparam int ActivePerFrame  = PanelHdisplay * PanelVdisplay;
	// FIFO content, one request accepted after the stall and the pixel on the output
	localparam int DrainPixels     = VideoTxPkg::PixelFifoDepth + 2;
	// Geometry 2, pixels 3, backlight window 2, underrun 2
	localparam int TestFrames      = 9;
	localparam int MarginCycles    = 3000;
	localparam busAdrsIdle         = 16'h0000;

	logic                sysClk = 1'b0;
	logic                rstN;
	VideoTxPkg::busAdrsT csrAdrs;
	VideoTxPkg::csrDataT csrWd;
	logic                csrWCke;
	VideoTxPkg::csrDataT csrRd;
	logic                csrREd;
	logic                memRdy;
	VideoTxPkg::pixelT   memRd;
	logic                memRVd;
	VideoTxPkg::memAdrsT memAdrs;
	logic                memREd;
	logic [3:0]          tftColorR;
	logic [3:0]          tftColorG;
	logic [3:0]          tftColorB;
	logic                tftHSync;
	logic                tftVSync;
	logic                tftDe;
	logic                tftRst;
	logic                tftBackLight;
	logic                stallMem = 1'b0;
	logic                checkPixels = 1'b0;
	int                  memLimitErrors;
	int                  pixelIndex = 0;
	int                  errors = 0;
	int                  checks = 0;

	logic [7:0] setupOffset [12] = '{VideoTxPkg::RegHdisplay, VideoTxPkg::RegVdisplay,
		VideoTxPkg::RegHSyncStart, VideoTxPkg::RegHSyncEnd, VideoTxPkg::RegHSyncMax,
		VideoTxPkg::RegVSyncStart, VideoTxPkg::RegVSyncEnd, VideoTxPkg::RegVSyncMax,
		VideoTxPkg::RegControl, VideoTxPkg::RegBlDuty, VideoTxPkg::RegDmaAdrs,
		VideoTxPkg::RegDmaLen};
	int setupValue [12] = '{PanelHdisplay, PanelVdisplay, PanelHSyncStart, PanelHSyncEnd,
		PanelHSyncMax, PanelVSyncStart, PanelVSyncEnd, PanelVSyncMax, 0, 'h5A, DmaBase,
		DmaWords};

	always #(ClkPeriod / 2) sysClk = ~sysClk;

	VideoTxBlock uut (
		.sysClk(sysClk), .rstN(rstN),
		.csrAdrs(csrAdrs), .csrWd(csrWd), .csrWCke(csrWCke),
		.csrRd(csrRd), .csrREd(csrREd),
		.memRdy(memRdy), .memRd(memRd), .memRVd(memRVd),
		.memAdrs(memAdrs), .memREd(memREd),
		.tftColorR(tftColorR), .tftColorG(tftColorG), .tftColorB(tftColorB),
		.tftHSync(tftHSync), .tftVSync(tftVSync), .tftDe(tftDe),
		.tftRst(tftRst), .tftBackLight(tftBackLight)
	);

	UfiMemModel memModel (
		.sysClk(sysClk), .memAdrs(memAdrs), .memREd(memREd), .stall(stallMem),
		.memRdy(memRdy), .memRd(memRd), .memRVd(memRVd), .limitErrors(memLimitErrors)
	);

	// ----------------------------------------------------------
	// Reference model and check helpers
	// ----------------------------------------------------------
	function automatic int expectedColor(input int index);
		int          adrs;
		logic [15:0] word;
		adrs = DmaBase + (index % DmaWords);
		word = 16'(adrs * 32'h9E37 + 32'h1234);
		// RGB565 top bits, 4 per channel
		return {word[15:12], word[10:7], word[4:1]};
	endfunction

	task automatic checkValue(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual)
		else
		begin
			errors++;
			$display("** Error %s: expected 0x%0h, actual 0x%0h at %0t",
				name, expected, actual, $time);
		end
	endtask

	task automatic writeReg(input logic [7:0] offset, input int data);
		@(posedge sysClk);
		#1;
		csrAdrs = {VideoTxPkg::BlockAdrsMap, offset};
		csrWd   = VideoTxPkg::csrDataT'(data);
		csrWCke = 1'b1;
		@(posedge sysClk);
		#1;
		csrAdrs = busAdrsIdle;
		csrWd   = '0;
		csrWCke = 1'b0;
	endtask

	task automatic checkReg(input string name, input logic [7:0] offset, input int expected);
		@(posedge sysClk);
		#1;
		csrAdrs = {VideoTxPkg::BlockAdrsMap, offset};
		csrWCke = 1'b0;
		@(negedge sysClk);
		checkValue({name, " csrREd early"}, 0, csrREd);
		@(posedge sysClk);
		#1;
		csrAdrs = busAdrsIdle;
		@(negedge sysClk);
		checkValue({name, " csrREd"}, 1, csrREd);
		checkValue(name, expected, csrRd);
	endtask

	// Every active pixel against the reference
	always @(negedge sysClk)
	begin
		if (checkPixels && tftDe)
		begin
			checkValue($sformatf("pixel %0d colour", pixelIndex), expectedColor(pixelIndex),
				{tftColorR, tftColorG, tftColorB});
			pixelIndex++;
		end
	end

	// ----------------------------------------------------------
	// Test steps
	// ----------------------------------------------------------
	task automatic testResetState();
		@(negedge sysClk);
		checkValue("reset tftDe", 0, tftDe);
		checkValue("reset tftHSync", 1, tftHSync);
		checkValue("reset tftVSync", 1, tftVSync);
		checkValue("reset tftRst", 0, tftRst);
		checkValue("reset tftBackLight", 0, tftBackLight);
		checkValue("reset memREd", 0, memREd);
		checkValue("reset csrREd", 0, csrREd);
		checkReg("default hdisplay", VideoTxPkg::RegHdisplay, 480);
		checkReg("default vdisplay", VideoTxPkg::RegVdisplay, 272);
		checkReg("default hSyncStart", VideoTxPkg::RegHSyncStart, 488);
		checkReg("default hSyncEnd", VideoTxPkg::RegHSyncEnd, 498);
		checkReg("default hSyncMax", VideoTxPkg::RegHSyncMax, 540);
		checkReg("default vSyncStart", VideoTxPkg::RegVSyncStart, 284);
		checkReg("default vSyncEnd", VideoTxPkg::RegVSyncEnd, 294);
		checkReg("default vSyncMax", VideoTxPkg::RegVSyncMax, 297);
		checkReg("default control", VideoTxPkg::RegControl, 1);
		checkReg("default blDuty", VideoTxPkg::RegBlDuty, 0);
		checkReg("default dmaAdrs", VideoTxPkg::RegDmaAdrs, 0);
		checkReg("default dmaLen", VideoTxPkg::RegDmaLen, 0);
		checkReg("default status", VideoTxPkg::RegStatus, 0);
	endtask

	task automatic testRegisterAccess();
		int i;
		for (i = 0; i < 12; i++)
			writeReg(setupOffset[i], setupValue[i]);
		for (i = 0; i < 12; i++)
			checkReg($sformatf("read-back 0x%02h", setupOffset[i]), setupOffset[i], setupValue[i]);
		checkReg("unknown offset 0x34", 8'h34, 0);
		checkReg("unknown offset 0x3C", 8'h3C, 0);
	endtask

	task automatic startVideo();
		// DMA fills the FIFO while the display is still held
		writeReg(VideoTxPkg::RegControl, 3);
		repeat (100) @(posedge sysClk);
		pixelIndex  = 0;
		checkPixels = 1'b1;
		writeReg(VideoTxPkg::RegControl, 2);
		@(negedge sysClk);
		checkValue("tftRst after release", 1, tftRst);
	endtask

	task automatic measureSyncGeometry();
		int   cyc;
		int   hLowRun;
		int   vLowRun;
		int   deRun;
		int   lastHFall;
		int   activeLines;
		int   frames;
		logic prevH;
		logic prevV;
		logic prevDe;
		// Align on a falling vsync
		@(negedge sysClk);
		do
		begin
			prevV = tftVSync;
			@(negedge sysClk);
		end
		while (!prevV || tftVSync);
		prevH       = tftHSync;
		prevV       = tftVSync;
		prevDe      = tftDe;
		hLowRun     = 0;
		vLowRun     = 1;
		deRun       = 0;
		lastHFall   = -1;
		activeLines = 0;
		frames      = 0;
		for (cyc = 1; cyc <= 2 * FrameCycles; cyc++)
		begin
			@(negedge sysClk);
			if (!tftHSync)
				hLowRun++;
			if (prevH && !tftHSync)
			begin
				if (lastHFall >= 0)
					checkValue("line period", LineCycles, cyc - lastHFall);
				lastHFall = cyc;
			end
			if (!prevH && tftHSync)
			begin
				checkValue("hsync width", PanelHSyncEnd - PanelHSyncStart, hLowRun);
				hLowRun = 0;
			end
			if (tftDe)
				deRun++;
			if (prevDe && !tftDe)
			begin
				checkValue("active pixels per line", PanelHdisplay, deRun);
				deRun = 0;
				activeLines++;
			end
			if (!tftVSync)
				vLowRun++;
			if (!prevV && tftVSync)
			begin
				checkValue("vsync width", (PanelVSyncEnd - PanelVSyncStart) * LineCycles, vLowRun);
				vLowRun = 0;
			end
			if (prevV && !tftVSync)
			begin
				checkValue("active lines per frame", PanelVdisplay, activeLines);
				activeLines = 0;
				frames++;
			end
			prevH  = tftHSync;
			prevV  = tftVSync;
			prevDe = tftDe;
		end
		checkValue("frames measured", 2, frames);
	endtask

	task automatic verifyPixelRun();
		// Two geometry frames plus three more
		wait (pixelIndex >= 5 * ActivePerFrame);
		checkReg("status after pixel run", VideoTxPkg::RegStatus, 0);
	endtask

	task automatic measureBacklight();
		int highCycles;
		writeReg(VideoTxPkg::RegBlDuty, 64);
		repeat (4) @(negedge sysClk);
		highCycles = 0;
		repeat (256)
		begin
			@(negedge sysClk);
			if (tftBackLight)
				highCycles++;
		end
		checkValue("backlight high cycles", 64, highCycles);
	endtask

	task automatic provokeUnderrun();
		int seen;
		@(posedge sysClk);
		#1;
		checkPixels = 1'b0;
		stallMem    = 1'b1;
		seen        = 0;
		while (seen < 2 * ActivePerFrame)
		begin
			@(negedge sysClk);
			if (tftDe)
			begin
				if (seen >= DrainPixels)
					checkValue("black after drain", 0, {tftColorR, tftColorG, tftColorB});
				seen++;
			end
		end
		checkReg("status underrun", VideoTxPkg::RegStatus, 1);
		writeReg(VideoTxPkg::RegControl, 3);
		stallMem = 1'b0;
		repeat (100) @(posedge sysClk);
		checkReg("status in display reset", VideoTxPkg::RegStatus, 0);
		writeReg(VideoTxPkg::RegControl, 2);
		repeat (LineCycles) @(posedge sysClk);
		checkReg("status after restart", VideoTxPkg::RegStatus, 0);
	endtask

	// ----------------------------------------------------------
	// Main sequence and watchdog
	// ----------------------------------------------------------
	initial
	begin
		void'($urandom(96590));
		rstN    = 1'b0;
		csrAdrs = busAdrsIdle;
		csrWd   = '0;
		csrWCke = 1'b0;
		repeat (8) @(posedge sysClk);
		#1;
		rstN = 1'b1;
		testResetState();
		testRegisterAccess();
		startVideo();
		measureSyncGeometry();
		verifyPixelRun();
		measureBacklight();
		provokeUnderrun();
		$display("Checks: %0d, errors: %0d, memory limit errors: %0d",
			checks, errors, memLimitErrors);
		if (errors == 0 && memLimitErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#((TestFrames * FrameCycles + MarginCycles) * ClkPeriod);
		$display("Watchdog timeout: the tests did not complete in the expected time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule
